//--- flist.f
+incdir+sim
logic/exe_pkg.sv
logic/fu_alu.sv
logic/fu_logic.sv
logic/fu_branch.sv
logic/fu_mult.sv
logic/fu_lsu.sv
logic/execute_stage.sv
sim/execute_stage_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - logic/exe_pkg.sv
  - logic/fu_alu.sv
  - logic/fu_logic.sv
  - logic/fu_branch.sv
  - logic/fu_mult.sv
  - logic/fu_lsu.sv
  - logic/execute_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/execute_stage_tb.sv

//--- sim/exe_test_table.svh
`ifndef EXE_TEST_TABLE_SVH
`define EXE_TEST_TABLE_SVH

// one issued instruction and what the stage should give back for it
typedef struct {
  string               name;
  int                  unit;
  issued_instruction_t instr;
  bit                  mispredict;
  bit                  bypass_v;
  logic [31:0]         bypass_val;
  bit                  flushed;
  bit                  b2b;
  rob_wb_t             exp_rob;
  reg_wb_t             exp_reg;
  cdb_t                exp_cdb;
  bit                  exp_sb_v;
  sb_entry_t           exp_sb;
  int                  latency;
  bit                  issued;
  int                  due;
} test_row_t;

test_row_t rows[$];

// tags follow the row number so every result is traceable
task automatic add_row(input string name, input int unit, input opcode_e op, input bit imm,
                       input logic [31:0] rs1, input logic [31:0] rs2,
                       input logic [31:0] immv, input logic [31:0] pc,
                       input bit mispredict, input bit bypass_v,
                       input logic [31:0] bypass_val, input bit flushed, input bit b2b);
  test_row_t r;
  r.name                   = name;
  r.unit                   = unit;
  r.instr.opcode           = op;
  r.instr.imm              = imm;
  r.instr.w_v              = 1'b1;
  r.instr.pc               = pc;
  r.instr.source_1_data    = rs1;
  r.instr.source2_imm      = immv;
  r.instr.source2_imm_data = rs2;
  r.instr.rob_dest         = ROB_TAG_W'(rows.size());
  r.instr.dest_id          = REG_TAG_W'(rows.size() + 1);
  r.instr.sb_dest          = SB_TAG_W'(rows.size());
  r.mispredict             = mispredict;
  r.bypass_v               = bypass_v;
  r.bypass_val             = bypass_val;
  r.flushed                = flushed;
  r.b2b                    = b2b;
  r.issued                 = 1'b0;
  r.due                    = 0;
  rows.push_back(r);
endtask

// args after the name: unit, op, imm, rs1, rs2, immediate, pc,
// mispredict, bypass valid, bypass value, flushed, back to back
task automatic build_table();
  add_row("add_reg", ALU_FU, ADD, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("add_imm", ALU_FU, ADD, 1'b1, $random(seed), $random(seed), 32'hFFFF_FFFB, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("sub_reg", ALU_FU, SUB, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("sub_imm_no_wb", ALU_FU, SUB, 1'b1, $random(seed), $random(seed), 32'h3, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  // rob only, no register destination
  rows[rows.size()-1].instr.w_v = 1'b0;
  add_row("slt_neg", ALU_FU, SLT, 1'b0, 32'hFFFF_FFFD, 32'h2, 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("slt_imm", ALU_FU, SLT, 1'b1, 32'h7, $random(seed), 32'hFFFF_FFFF, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("sll_reg", ALU_FU, SLL, 1'b0, $random(seed), 32'h0000_0125, 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("srl_imm", ALU_FU, SRL, 1'b1, 32'h8000_0000, $random(seed), 32'd31, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("and_reg", LOGICAL_FU, AND, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("or_imm", LOGICAL_FU, OR, 1'b1, $random(seed), $random(seed), 32'h0F0F, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("xor_reg", LOGICAL_FU, XOR, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("beq_taken", BRANCH_FU, BEQ, 1'b0, 32'h5, 32'h5, 32'h40, 32'h1000,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("beq_not", BRANCH_FU, BEQ, 1'b0, 32'h5, 32'h6, 32'hFFFF_FFF0, 32'h1100,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("bne_taken", BRANCH_FU, BNE, 1'b0, 32'h1, 32'h2, 32'h20, 32'h1200,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("bne_not", BRANCH_FU, BNE, 1'b0, 32'h7, 32'h7, 32'h30, 32'h1280,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("blt_taken", BRANCH_FU, BLT, 1'b0, 32'hFFFF_FFFF, 32'h1, 32'h8, 32'h1300,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("blt_not", BRANCH_FU, BLT, 1'b0, 32'h1, 32'hFFFF_FFFF, 32'h8, 32'h1400,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("jal", BRANCH_FU, JAL, 1'b1, 32'h0, 32'h0, 32'h0000_0800, 32'h2000,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("mul_0", MUL_FU, MUL, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
  add_row("mul_1", MUL_FU, MUL, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
  add_row("mul_2", MUL_FU, MUL, 1'b1, $random(seed), $random(seed), 32'hFFFF_FFF9, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("lw_mem", MEM_FU, LW, 1'b1, 32'h0000_3000, $random(seed), 32'h24, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("lw_bypass", MEM_FU, LW, 1'b1, 32'h0000_3000, $random(seed), 32'hFFFF_FFFC, 32'h0,
          1'b0, 1'b1, 32'h1234_5678, 1'b0, 1'b0);
  add_row("sw", MEM_FU, SW, 1'b1, 32'h0000_4000, $random(seed), 32'h10, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  add_row("mispredict_alu", ALU_FU, ADD, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b1, 1'b0, 32'h0, 1'b1, 1'b0);
  add_row("mul_flushed", MUL_FU, MUL, 1'b0, $random(seed), $random(seed), 32'h0, 32'h0,
          1'b0, 1'b0, 32'h0, 1'b1, 1'b1);
  add_row("mispredict_after_mul", LOGICAL_FU, XOR, 1'b0, $random(seed), $random(seed),
          32'h0, 32'h0, 1'b1, 1'b0, 32'h0, 1'b1, 1'b0);
endtask

`endif

//--- sim/execute_stage_tb.sv
`default_nettype none

module execute_stage_tb import exe_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MUL_STAGES = 3;

  logic                   clk;
  logic                   rst;
  logic [NUM_FU-1:0]      issue_exe_v;
  issued_instruction_t    issue_exe;
  cdb_t    [NUM_FU-1:0]   cdb;
  rob_wb_t [NUM_FU-1:0]   exe_rob;
  reg_wb_t [NUM_FU-1:0]   exe_reg;
  logic                   lsu_sb_v;
  sb_entry_t              lsu_sb;
  logic [WORD_SIZE_P-1:0] bypass_addr;
  logic [SB_TAG_W-1:0]    bypass_sb_num;
  logic                   bypass_valid;
  logic [WORD_SIZE_P-1:0] bypass_value;
  logic [WORD_SIZE_P-1:0] lsu_addr;
  logic [WORD_SIZE_P-1:0] mem_data;
  logic                   mispredict;

  integer seed = 41;
  int     cycle_cnt = 0;
  bit     table_ready = 1'b0;
  int     passed = 0;
  int     failed = 0;
  int     checked = 0;
  int     stray_errors = 0;

  `include "exe_test_table.svh"

  execute_stage #(
    .MUL_STAGES (MUL_STAGES)
  ) dut (
    .clk_i                  (clk),
    .rst_i                  (rst),
    .issue_exe_v_i          (issue_exe_v),
    .issue_exe_i            (issue_exe),
    .cdb_o                  (cdb),
    .exe_rob_o              (exe_rob),
    .exe_reg_o              (exe_reg),
    .lsu_sb_v_o             (lsu_sb_v),
    .lsu_sb_o               (lsu_sb),
    .exe_ld_bypass_addr_o   (bypass_addr),
    .exe_ld_bypass_sb_num_o (bypass_sb_num),
    .sb_ld_bypass_valid_i   (bypass_valid),
    .sb_ld_bypass_value_i   (bypass_value),
    .lsu_addr_o             (lsu_addr),
    .mem_data_i             (mem_data),
    .mispredict_i           (mispredict)
  );

  // data memory model
  assign mem_data = lsu_addr ^ 32'hA5A5_0000;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // reference results straight from the instruction rules
  function automatic test_row_t fill_expected(input test_row_t r);
    issued_instruction_t ins;
    logic [31:0]         op2;
    logic [31:0]         addr;
    logic [31:0]         data;
    logic                taken;
    logic                reg_v;
    ins   = r.instr;
    op2   = ins.imm ? ins.source2_imm : ins.source2_imm_data;
    addr  = ins.source_1_data + ins.source2_imm;
    data  = '0;
    taken = 1'b0;
    r.latency  = (r.unit == MUL_FU) ? MUL_STAGES : 1;
    r.exp_sb_v = (ins.opcode == SW);
    r.exp_sb   = '{sb_dest: ins.sb_dest, addr: addr, data: ins.source2_imm_data};
    case (ins.opcode)
      ADD: data = ins.source_1_data + op2;
      SUB: data = ins.source_1_data - op2;
      SLT: data = ($signed(ins.source_1_data) < $signed(op2)) ? 32'd1 : 32'd0;
      SLL: data = ins.source_1_data << op2[4:0];
      SRL: data = ins.source_1_data >> op2[4:0];
      AND: data = ins.source_1_data & op2;
      OR:  data = ins.source_1_data | op2;
      XOR: data = ins.source_1_data ^ op2;
      BEQ: taken = (ins.source_1_data == op2);
      BNE: taken = (ins.source_1_data != op2);
      BLT: taken = ($signed(ins.source_1_data) < $signed(op2));
      JAL: begin
        taken = 1'b1;
        data  = ins.pc + 32'd4;
      end
      MUL: data = ins.source_1_data * op2;
      LW:  data = r.bypass_v ? r.bypass_val : (addr ^ 32'hA5A5_0000);
      default: data = '0;
    endcase
    case (r.unit)
      ALU_FU:    reg_v = ins.w_v;
      BRANCH_FU: reg_v = (ins.opcode == JAL);
      MEM_FU:    reg_v = (ins.opcode == LW);
      default:   reg_v = 1'b1;
    endcase
    r.exp_rob = '{valid: 1'b1, rob_dest: ins.rob_dest, data: data, taken: taken,
                  target: (r.unit == BRANCH_FU) ? ins.pc + ins.source2_imm : 32'h0};
    r.exp_reg = '{valid: reg_v, dest_id: ins.dest_id, data: data};
    r.exp_cdb = '{valid: 1'b1, rob_dest: ins.rob_dest, data: data};
    if (r.flushed) begin
      r.exp_rob.valid = 1'b0;
      r.exp_reg.valid = 1'b0;
      r.exp_cdb.valid = 1'b0;
      r.exp_sb_v      = 1'b0;
    end
    return r;
  endfunction

  task automatic check_value(input string test, input string what, input logic [127:0] exp,
                             input logic [127:0] act, inout int errs);
    assert (act === exp) else begin
      $display("Fail %s %s expected %0h actual %0h", test, what, exp, act);
      errs++;
    end
  endtask

  task automatic check_row(input int idx);
    test_row_t r;
    int        u;
    int        errs;
    r    = rows[idx];
    u    = r.unit;
    errs = 0;
    if (r.exp_rob.valid) check_value(r.name, "rob", r.exp_rob, exe_rob[u], errs);
    else check_value(r.name, "rob valid", 0, exe_rob[u].valid, errs);
    if (r.exp_reg.valid) check_value(r.name, "reg", r.exp_reg, exe_reg[u], errs);
    else check_value(r.name, "reg valid", 0, exe_reg[u].valid, errs);
    if (r.exp_cdb.valid) check_value(r.name, "cdb", r.exp_cdb, cdb[u], errs);
    else check_value(r.name, "cdb valid", 0, cdb[u].valid, errs);
    if (u == MEM_FU) begin
      check_value(r.name, "sb valid", r.exp_sb_v, lsu_sb_v, errs);
      if (r.exp_sb_v) check_value(r.name, "sb entry", r.exp_sb, lsu_sb, errs);
    end
    if (errs == 0) begin
      $display("%s: ok", r.name);
      passed++;
    end else begin
      $display("%s: %0d mismatches", r.name, errs);
      failed++;
    end
    checked++;
  endtask

  // nothing due on this unit, so it has to stay quiet
  task automatic check_idle(input int u);
    assert (!exe_rob[u].valid && !exe_reg[u].valid && !cdb[u].valid) else begin
      $display("unit %0d raised a valid output in cycle %0d with nothing due", u, cycle_cnt);
      stray_errors++;
    end
    if (u == DIV_FU || u == NOOP_FU) begin
      assert (exe_rob[u] == '0 && exe_reg[u] == '0 && cdb[u] == '0) else begin
        $display("unused unit slot %0d is not tied to zero", u);
        stray_errors++;
      end
    end
    if (u == MEM_FU) begin
      assert (!lsu_sb_v) else begin
        $display("store buffer write pulsed in cycle %0d with no store due", cycle_cnt);
        stray_errors++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst && table_ready) begin
      for (int u = 0; u < NUM_FU; u++) begin
        int idx;
        idx = -1;
        foreach (rows[i]) begin
          if (rows[i].issued && rows[i].due == cycle_cnt && rows[i].unit == u) idx = i;
        end
        if (idx >= 0) check_row(idx);
        else check_idle(u);
      end
    end
  end

  task automatic idle_inputs();
    issue_exe_v  = '0;
    issue_exe    = '0;
    mispredict   = 1'b0;
    bypass_valid = 1'b0;
    bypass_value = '0;
  endtask

  task automatic drive_row(input int idx);
    logic [31:0] addr;
    issue_exe_v               = '0;
    issue_exe_v[rows[idx].unit] = 1'b1;
    issue_exe                 = rows[idx].instr;
    mispredict                = rows[idx].mispredict;
    bypass_valid              = rows[idx].bypass_v;
    bypass_value              = rows[idx].bypass_val;
    rows[idx].issued          = 1'b1;
    rows[idx].due             = cycle_cnt + rows[idx].latency;
    // address and bypass lookup are combinational in the issue cycle
    if (rows[idx].unit == MEM_FU) begin
      addr = rows[idx].instr.source_1_data + rows[idx].instr.source2_imm;
      #2;
      assert (lsu_addr === addr) else begin
        $display("Fail %s lsu address expected %0h actual %0h", rows[idx].name, addr, lsu_addr);
        stray_errors++;
      end
      assert (bypass_addr === addr) else begin
        $display("Fail %s bypass address expected %0h actual %0h", rows[idx].name, addr,
                 bypass_addr);
        stray_errors++;
      end
      assert (bypass_sb_num === rows[idx].instr.sb_dest) else begin
        $display("Fail %s sb number expected %0h actual %0h", rows[idx].name,
                 rows[idx].instr.sb_dest, bypass_sb_num);
        stray_errors++;
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    idle_inputs();
    build_table();
    foreach (rows[i]) rows[i] = fill_expected(rows[i]);
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    repeat (2) @(posedge clk);
    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      drive_row(i);
      if (!rows[i].b2b) begin
        @(posedge clk);
        #1;
        idle_inputs();
        repeat (2) @(posedge clk);
      end
    end
    repeat (MUL_STAGES + 3) @(posedge clk);
    @(negedge clk);
    #1;
    $display("tests %0d  passed %0d  failed %0d  other errors %0d",
             rows.size(), passed, failed, stray_errors);
    if (failed == 0 && stray_errors == 0 && checked == rows.size()) begin
      $display("SIMULATION PASSED");
    end else begin
      if (checked != rows.size())
        $display("only %0d of %0d tests reached their check", checked, rows.size());
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ten cycles per row is far more than any row needs
  initial begin
    wait (table_ready);
    repeat (rows.size() * 10 + 100) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage import exe_pkg::*; #(
  parameter int MUL_STAGES = 3
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire [NUM_FU-1:0]           issue_exe_v_i,
  input  wire issued_instruction_t   issue_exe_i,
  output wire cdb_t    [NUM_FU-1:0]  cdb_o,
  output wire rob_wb_t [NUM_FU-1:0]  exe_rob_o,
  output wire reg_wb_t [NUM_FU-1:0]  exe_reg_o,
  // store buffer
  output wire                        lsu_sb_v_o,
  output wire sb_entry_t             lsu_sb_o,
  output wire [WORD_SIZE_P-1:0]      exe_ld_bypass_addr_o,
  output wire [SB_TAG_W-1:0]         exe_ld_bypass_sb_num_o,
  input  wire                        sb_ld_bypass_valid_i,
  input  wire [WORD_SIZE_P-1:0]      sb_ld_bypass_value_i,
  // data memory
  output wire [WORD_SIZE_P-1:0]      lsu_addr_o,
  input  wire [WORD_SIZE_P-1:0]      mem_data_i,
  input  wire                        mispredict_i
);

  logic [NUM_FU-1:0]      exe_v;
  logic [WORD_SIZE_P-1:0] operand2;

  // no new work enters any unit on a mispredict
  assign exe_v = issue_exe_v_i & {NUM_FU{~mispredict_i}};

  assign operand2 = issue_exe_i.imm ? issue_exe_i.source2_imm : issue_exe_i.source2_imm_data;

  // divider and noop slots are not built
  assign cdb_o[DIV_FU]      = '0;
  assign exe_rob_o[DIV_FU]  = '0;
  assign exe_reg_o[DIV_FU]  = '0;
  assign cdb_o[NOOP_FU]     = '0;
  assign exe_rob_o[NOOP_FU] = '0;
  assign exe_reg_o[NOOP_FU] = '0;

  // units without their own bus port
  assign cdb_o[LOGICAL_FU] = exe_rob_o[LOGICAL_FU][ROB_WB_WIDTH-1 -: CDB_WIDTH];
  assign cdb_o[MUL_FU]     = exe_rob_o[MUL_FU][ROB_WB_WIDTH-1 -: CDB_WIDTH];

  fu_alu u_alu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .exe_v_i    (exe_v[ALU_FU]),
    .opcode_i   (issue_exe_i.opcode),
    .w_v_i      (issue_exe_i.w_v),
    .operand1_i (issue_exe_i.source_1_data),
    .operand2_i (operand2),
    .rob_dest_i (issue_exe_i.rob_dest),
    .reg_dest_i (issue_exe_i.dest_id),
    .alu_rob_o  (exe_rob_o[ALU_FU]),
    .alu_reg_o  (exe_reg_o[ALU_FU]),
    .cdb_o      (cdb_o[ALU_FU])
  );

  fu_logic u_logic (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .exe_v_i     (exe_v[LOGICAL_FU]),
    .opcode_i    (issue_exe_i.opcode),
    .operand1_i  (issue_exe_i.source_1_data),
    .operand2_i  (operand2),
    .rob_dest_i  (issue_exe_i.rob_dest),
    .reg_dest_i  (issue_exe_i.dest_id),
    .logic_rob_o (exe_rob_o[LOGICAL_FU]),
    .logic_reg_o (exe_reg_o[LOGICAL_FU])
  );

  fu_branch u_branch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .exe_v_i      (exe_v[BRANCH_FU]),
    .opcode_i     (issue_exe_i.opcode),
    .pc_i         (issue_exe_i.pc),
    .operand1_i   (issue_exe_i.source_1_data),
    .operand2_i   (operand2),
    .imm_i        (issue_exe_i.source2_imm),
    .rob_dest_i   (issue_exe_i.rob_dest),
    .reg_dest_i   (issue_exe_i.dest_id),
    .branch_rob_o (exe_rob_o[BRANCH_FU]),
    .branch_reg_o (exe_reg_o[BRANCH_FU]),
    .cdb_o        (cdb_o[BRANCH_FU])
  );

  fu_mult #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mult (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .exe_v_i      (exe_v[MUL_FU]),
    .mispredict_i (mispredict_i),
    .operand1_i   (issue_exe_i.source_1_data),
    .operand2_i   (operand2),
    .rob_dest_i   (issue_exe_i.rob_dest),
    .reg_dest_i   (issue_exe_i.dest_id),
    .mult_rob_o   (exe_rob_o[MUL_FU]),
    .mult_reg_o   (exe_reg_o[MUL_FU])
  );

  // address from the immediate, store data from the register
  fu_lsu u_lsu (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .exe_v_i                (exe_v[MEM_FU]),
    .opcode_i               (issue_exe_i.opcode),
    .operand1_i             (issue_exe_i.source_1_data),
    .operand2_i             (issue_exe_i.source2_imm_data),
    .imm_i                  (issue_exe_i.source2_imm),
    .rob_dest_i             (issue_exe_i.rob_dest),
    .reg_dest_i             (issue_exe_i.dest_id),
    .sb_dest_i              (issue_exe_i.sb_dest),
    .lsu_rob_o              (exe_rob_o[MEM_FU]),
    .lsu_reg_o              (exe_reg_o[MEM_FU]),
    .cdb_o                  (cdb_o[MEM_FU]),
    .lsu_sb_v_o             (lsu_sb_v_o),
    .lsu_sb_o               (lsu_sb_o),
    .exe_ld_bypass_addr_o   (exe_ld_bypass_addr_o),
    .exe_ld_bypass_sb_num_o (exe_ld_bypass_sb_num_o),
    .sb_ld_bypass_valid_i   (sb_ld_bypass_valid_i),
    .sb_ld_bypass_value_i   (sb_ld_bypass_value_i),
    .lsu_addr_o             (lsu_addr_o),
    .mem_data_i             (mem_data_i)
  );

endmodule

`default_nettype wire

//--- logic/fu_lsu.sv
`default_nettype none

module fu_lsu import exe_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   exe_v_i,
  input  wire opcode_e          opcode_i,
  input  wire [WORD_SIZE_P-1:0] operand1_i,
  input  wire [WORD_SIZE_P-1:0] operand2_i,
  input  wire [WORD_SIZE_P-1:0] imm_i,
  input  wire [ROB_TAG_W-1:0]   rob_dest_i,
  input  wire [REG_TAG_W-1:0]   reg_dest_i,
  input  wire [SB_TAG_W-1:0]    sb_dest_i,
  output rob_wb_t               lsu_rob_o,
  output reg_wb_t               lsu_reg_o,
  output cdb_t                  cdb_o,
  // store buffer side
  output logic                  lsu_sb_v_o,
  output sb_entry_t             lsu_sb_o,
  output logic [WORD_SIZE_P-1:0] exe_ld_bypass_addr_o,
  output logic [SB_TAG_W-1:0]   exe_ld_bypass_sb_num_o,
  input  wire                   sb_ld_bypass_valid_i,
  input  wire [WORD_SIZE_P-1:0] sb_ld_bypass_value_i,
  // data memory
  output logic [WORD_SIZE_P-1:0] lsu_addr_o,
  input  wire [WORD_SIZE_P-1:0] mem_data_i
);

  logic [WORD_SIZE_P-1:0] addr;
  logic [WORD_SIZE_P-1:0] ld_data;
  logic                   is_load;
  logic                   is_store;

  logic                   valid_q;
  logic                   load_q;
  logic                   sb_v_q;
  logic [ROB_TAG_W-1:0]   rob_dest_q;
  logic [REG_TAG_W-1:0]   reg_dest_q;
  logic [WORD_SIZE_P-1:0] data_q;
  sb_entry_t              sb_q;

  assign addr     = operand1_i + imm_i;
  assign is_load  = (opcode_i == LW);
  assign is_store = (opcode_i == SW);

  // bypass lookup and memory read happen in the issue cycle
  assign exe_ld_bypass_addr_o   = addr;
  assign exe_ld_bypass_sb_num_o = sb_dest_i;
  assign lsu_addr_o             = addr;

  // newer store data in the buffer wins over memory
  assign ld_data = sb_ld_bypass_valid_i ? sb_ld_bypass_value_i : mem_data_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      sb_v_q  <= 1'b0;
    end else begin
      valid_q <= exe_v_i & (is_load | is_store);
      sb_v_q  <= exe_v_i & is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      load_q     <= is_load;
      rob_dest_q <= rob_dest_i;
      reg_dest_q <= reg_dest_i;
      data_q     <= is_load ? ld_data : '0;
      sb_q       <= '{sb_dest: sb_dest_i, addr: addr, data: operand2_i};
    end
  end

  assign lsu_rob_o = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q,
                       taken: 1'b0, target: '0};
  assign lsu_reg_o = '{valid: valid_q & load_q, dest_id: reg_dest_q, data: data_q};
  assign cdb_o     = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q};

  assign lsu_sb_v_o = sb_v_q;
  assign lsu_sb_o   = sb_q;

endmodule

`default_nettype wire

//--- logic/fu_mult.sv
`default_nettype none

module fu_mult import exe_pkg::*; #(
  parameter int MUL_STAGES = 3
) (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   exe_v_i,
  input  wire                   mispredict_i,
  input  wire [WORD_SIZE_P-1:0] operand1_i,
  input  wire [WORD_SIZE_P-1:0] operand2_i,
  input  wire [ROB_TAG_W-1:0]   rob_dest_i,
  input  wire [REG_TAG_W-1:0]   reg_dest_i,
  output rob_wb_t               mult_rob_o,
  output reg_wb_t               mult_reg_o
);

  typedef struct packed {
    logic [ROB_TAG_W-1:0]   rob_dest;
    logic [REG_TAG_W-1:0]   dest_id;
    logic [WORD_SIZE_P-1:0] data;
  } mul_stage_t;

  // low word only, sign does not matter here
  logic [WORD_SIZE_P-1:0] product;

  logic [MUL_STAGES-1:0]  valid_q;
  mul_stage_t [MUL_STAGES-1:0] stage_q;

  assign product = operand1_i * operand2_i;

  // flush drops everything still in flight
  always_ff @(posedge clk_i) begin
    if (rst_i || mispredict_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= exe_v_i;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    stage_q[0] <= '{rob_dest: rob_dest_i, dest_id: reg_dest_i, data: product};
    for (int i = 1; i < MUL_STAGES; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign mult_rob_o = '{valid:    valid_q[MUL_STAGES-1],
                        rob_dest: stage_q[MUL_STAGES-1].rob_dest,
                        data:     stage_q[MUL_STAGES-1].data,
                        taken:    1'b0,
                        target:   '0};
  assign mult_reg_o = '{valid:   valid_q[MUL_STAGES-1],
                        dest_id: stage_q[MUL_STAGES-1].dest_id,
                        data:    stage_q[MUL_STAGES-1].data};

endmodule

`default_nettype wire

//--- logic/fu_branch.sv
`default_nettype none

module fu_branch import exe_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   exe_v_i,
  input  wire opcode_e          opcode_i,
  input  wire [WORD_SIZE_P-1:0] pc_i,
  input  wire [WORD_SIZE_P-1:0] operand1_i,
  input  wire [WORD_SIZE_P-1:0] operand2_i,
  input  wire [WORD_SIZE_P-1:0] imm_i,
  input  wire [ROB_TAG_W-1:0]   rob_dest_i,
  input  wire [REG_TAG_W-1:0]   reg_dest_i,
  output rob_wb_t               branch_rob_o,
  output reg_wb_t               branch_reg_o,
  output cdb_t                  cdb_o
);

  logic                   taken;
  logic                   is_jal;
  logic [WORD_SIZE_P-1:0] link;

  logic                   valid_q;
  logic                   taken_q;
  logic                   jal_q;
  logic [WORD_SIZE_P-1:0] target_q;
  logic [WORD_SIZE_P-1:0] data_q;
  logic [ROB_TAG_W-1:0]   rob_dest_q;
  logic [REG_TAG_W-1:0]   reg_dest_q;

  assign is_jal = (opcode_i == JAL);
  assign link   = pc_i + WORD_SIZE_P'(4);

  always_comb begin
    case (opcode_i)
      BEQ:     taken = (operand1_i == operand2_i);
      BNE:     taken = (operand1_i != operand2_i);
      BLT:     taken = ($signed(operand1_i) < $signed(operand2_i));
      JAL:     taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      taken_q    <= taken;
      jal_q      <= is_jal;
      target_q   <= pc_i + imm_i;
      // only jal carries a link value
      data_q     <= is_jal ? link : '0;
      rob_dest_q <= rob_dest_i;
      reg_dest_q <= reg_dest_i;
    end
  end

  assign branch_rob_o = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q,
                          taken: taken_q, target: target_q};
  assign branch_reg_o = '{valid: valid_q & jal_q, dest_id: reg_dest_q, data: data_q};
  assign cdb_o        = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q};

endmodule

`default_nettype wire

//--- logic/fu_logic.sv
`default_nettype none

module fu_logic import exe_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   exe_v_i,
  input  wire opcode_e          opcode_i,
  input  wire [WORD_SIZE_P-1:0] operand1_i,
  input  wire [WORD_SIZE_P-1:0] operand2_i,
  input  wire [ROB_TAG_W-1:0]   rob_dest_i,
  input  wire [REG_TAG_W-1:0]   reg_dest_i,
  output rob_wb_t               logic_rob_o,
  output reg_wb_t               logic_reg_o
);

  logic [WORD_SIZE_P-1:0] result;

  logic                   valid_q;
  logic [ROB_TAG_W-1:0]   rob_dest_q;
  logic [REG_TAG_W-1:0]   reg_dest_q;
  logic [WORD_SIZE_P-1:0] data_q;

  always_comb begin
    case (opcode_i)
      AND:     result = operand1_i & operand2_i;
      OR:      result = operand1_i | operand2_i;
      XOR:     result = operand1_i ^ operand2_i;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      rob_dest_q <= rob_dest_i;
      reg_dest_q <= reg_dest_i;
      data_q     <= result;
    end
  end

  // bus word is cut out of the rob word at the top
  assign logic_rob_o = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q,
                         taken: 1'b0, target: '0};
  assign logic_reg_o = '{valid: valid_q, dest_id: reg_dest_q, data: data_q};

endmodule

`default_nettype wire

//--- logic/fu_alu.sv
`default_nettype none

module fu_alu import exe_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   exe_v_i,
  input  wire opcode_e          opcode_i,
  input  wire                   w_v_i,
  input  wire [WORD_SIZE_P-1:0] operand1_i,
  input  wire [WORD_SIZE_P-1:0] operand2_i,
  input  wire [ROB_TAG_W-1:0]   rob_dest_i,
  input  wire [REG_TAG_W-1:0]   reg_dest_i,
  output rob_wb_t               alu_rob_o,
  output reg_wb_t               alu_reg_o,
  output cdb_t                  cdb_o
);

  logic [WORD_SIZE_P-1:0] result;
  logic [4:0]             shamt;

  logic                   valid_q;
  logic                   w_v_q;
  logic [ROB_TAG_W-1:0]   rob_dest_q;
  logic [REG_TAG_W-1:0]   reg_dest_q;
  logic [WORD_SIZE_P-1:0] data_q;

  assign shamt = operand2_i[4:0];

  always_comb begin
    case (opcode_i)
      ADD:     result = operand1_i + operand2_i;
      SUB:     result = operand1_i - operand2_i;
      SLT:     result = {{(WORD_SIZE_P-1){1'b0}}, $signed(operand1_i) < $signed(operand2_i)};
      SLL:     result = operand1_i << shamt;
      SRL:     result = operand1_i >> shamt;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      w_v_q      <= w_v_i;
      rob_dest_q <= rob_dest_i;
      reg_dest_q <= reg_dest_i;
      data_q     <= result;
    end
  end

  assign alu_rob_o = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q,
                       taken: 1'b0, target: '0};
  assign alu_reg_o = '{valid: valid_q & w_v_q, dest_id: reg_dest_q, data: data_q};
  assign cdb_o     = '{valid: valid_q, rob_dest: rob_dest_q, data: data_q};

endmodule

`default_nettype wire

//--- logic/exe_pkg.sv
`default_nettype none

package exe_pkg;

  localparam int WORD_SIZE_P = 32;

  localparam int ROB_ENTRY = 32;
  localparam int REG_ENTRY = 32;
  localparam int SB_ENTRY  = 8;

  localparam int ROB_TAG_W = $clog2(ROB_ENTRY);
  localparam int REG_TAG_W = $clog2(REG_ENTRY);
  localparam int SB_TAG_W  = $clog2(SB_ENTRY);

  // functional unit slots in the result vectors
  localparam int NUM_FU     = 7;
  localparam int ALU_FU     = 0;
  localparam int LOGICAL_FU = 1;
  localparam int BRANCH_FU  = 2;
  localparam int MUL_FU     = 3;
  localparam int DIV_FU     = 4;
  localparam int MEM_FU     = 5;
  localparam int NOOP_FU    = 6;

  typedef enum logic [4:0] {
    ADD = 5'd0,
    SUB = 5'd1,
    SLT = 5'd2,
    SLL = 5'd3,
    SRL = 5'd4,
    AND = 5'd5,
    OR  = 5'd6,
    XOR = 5'd7,
    BEQ = 5'd8,
    BNE = 5'd9,
    BLT = 5'd10,
    JAL = 5'd11,
    MUL = 5'd12,
    LW  = 5'd13,
    SW  = 5'd14
  } opcode_e;

  typedef struct packed {
    opcode_e                opcode;
    logic                   imm;
    logic                   w_v;
    logic [WORD_SIZE_P-1:0] pc;
    logic [WORD_SIZE_P-1:0] source_1_data;
    // already sign extended
    logic [WORD_SIZE_P-1:0] source2_imm;
    logic [WORD_SIZE_P-1:0] source2_imm_data;
    logic [ROB_TAG_W-1:0]   rob_dest;
    logic [REG_TAG_W-1:0]   dest_id;
    logic [SB_TAG_W-1:0]    sb_dest;
  } issued_instruction_t;

  typedef struct packed {
    logic                   valid;
    logic [ROB_TAG_W-1:0]   rob_dest;
    logic [WORD_SIZE_P-1:0] data;
  } cdb_t;

  // first three fields line up with cdb_t
  typedef struct packed {
    logic                   valid;
    logic [ROB_TAG_W-1:0]   rob_dest;
    logic [WORD_SIZE_P-1:0] data;
    logic                   taken;
    logic [WORD_SIZE_P-1:0] target;
  } rob_wb_t;

  typedef struct packed {
    logic                   valid;
    logic [REG_TAG_W-1:0]   dest_id;
    logic [WORD_SIZE_P-1:0] data;
  } reg_wb_t;

  typedef struct packed {
    logic [SB_TAG_W-1:0]    sb_dest;
    logic [WORD_SIZE_P-1:0] addr;
    logic [WORD_SIZE_P-1:0] data;
  } sb_entry_t;

  localparam int CDB_WIDTH    = $bits(cdb_t);
  localparam int ROB_WB_WIDTH = $bits(rob_wb_t);

endpackage

`default_nettype wire
